// ==== include/plic_settings.svh ====
`ifndef PLIC_SETTINGS_SVH
`define PLIC_SETTINGS_SVH

// Interrupt sources, source 0 means no interrupt
`define PLIC_NDEV 8

// Targets, context 0 is M-mode and context 1 is S-mode
`define PLIC_NCTX 2

// Address map, byte addresses on the 28-bit slave port
`define PLIC_PRIO_BASE  28'hc000000 // One priority word per source
`define PLIC_PEND_BASE  28'hc001000 // Pending word, read only
`define PLIC_EN_BASE    28'hc002000 // Enable mask of context 0
`define PLIC_EN_STRIDE  28'h0000080 // Per context
`define PLIC_CTX_BASE   28'hc200000 // Threshold of context 0
`define PLIC_CTX_STRIDE 28'h0001000 // Per context
`define PLIC_CLAIM_OFS  28'h0000004 // Claim/complete inside a context block

// Priority words are 4 bytes apart
`define PLIC_WORD_BYTES 4

`endif

// ==== design/plic_pkg.sv ====
`include "plic_settings.svh"

package plic_pkg;

    // Register data as seen on the slave port
    typedef logic [31:0] plic_word_t;

    // Byte address on the slave port
    typedef logic [27:0] plic_addr_t;

    // One bit per interrupt source
    typedef logic [`PLIC_NDEV-1:0] plic_src_t;

    // Source number, 0 when nothing is eligible
    typedef logic [$clog2(`PLIC_NDEV)-1:0] plic_id_t;

    // Write request once both AW and W halves are held
    typedef struct packed {
        plic_addr_t addr;
        plic_word_t data;
    } plic_wr_t;

    // Claim issued by a read of a claim register
    typedef struct packed {
        plic_id_t id;  // Source to clear
        logic     ctx; // Context that claimed it
    } plic_claim_t;

endpackage

// ==== design/plic_axi_port.sv ====
`timescale 1ns/1ps

module plic_axi_port (
    input  logic                 clk,
    input  logic                 rst,
    // Write address channel
    input  plic_pkg::plic_addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    // Write data channel
    input  plic_pkg::plic_word_t wdata,
    input  logic                 wvalid,
    output logic                 wready,
    // Write response channel
    output logic                 bvalid,
    input  logic                 bready,
    // Read address channel
    input  plic_pkg::plic_addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    // Read data channel
    output logic                 rvalid,
    output plic_pkg::plic_word_t rdata,
    input  logic                 rready,
    // Register file side
    output logic                 wr_stb,
    output plic_pkg::plic_wr_t   wr,
    output logic                 rd_stb,
    output plic_pkg::plic_addr_t rd_addr,
    input  plic_pkg::plic_word_t rd_data
);
    logic aw_hs;
    logic w_hs;
    logic r_hs;
    logic b_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign r_hs  = rvalid && rready;
    assign b_hs  = bvalid && bready;

    // Read request goes straight to the register decode
    assign rd_stb  = arvalid && arready;
    assign rd_addr = araddr;

    // Both halves held and no response pending yet
    assign wr_stb = !awready && !wready && !bvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
            awready <= 1'b1;
            wready  <= 1'b1;
            bvalid  <= 1'b0;
        end else begin
            if (rd_stb) begin
                arready <= 1'b0; // One read in flight
                rvalid  <= 1'b1;
            end
            if (r_hs) begin
                rvalid  <= 1'b0;
                arready <= 1'b1;
            end
            if (aw_hs) begin
                awready <= 1'b0;
            end
            if (w_hs) begin
                wready <= 1'b0;
            end
            if (wr_stb) begin
                bvalid <= 1'b1; // Register updates at this same edge
            end
            if (b_hs) begin
                bvalid  <= 1'b0;
                awready <= 1'b1;
                wready  <= 1'b1;
            end
        end
    end

    // Captured payloads
    always_ff @(posedge clk) begin
        if (rd_stb) begin
            rdata <= rd_data;
        end
        if (aw_hs) begin
            wr.addr <= awaddr;
        end
        if (w_hs) begin
            wr.data <= wdata;
        end
    end

    // A new read is never taken while the previous data waits
    assert property (@(posedge clk) disable iff (rst) !(rvalid && arready));

    // Response only after both write halves were taken
    assert property (@(posedge clk) disable iff (rst) bvalid |-> (!awready && !wready));

endmodule

// ==== design/plic_gateway.sv ====
`timescale 1ns/1ps
`include "plic_settings.svh"

module plic_gateway (
    input  logic                  clk,
    input  logic                  rst,
    input  plic_pkg::plic_src_t   src,
    input  logic                  claim_stb,
    input  plic_pkg::plic_claim_t claim,
    output plic_pkg::plic_src_t   pending
);
    import plic_pkg::*;

    plic_src_t pending_nxt;

    always_comb begin
        pending_nxt = pending;
        for (int i = 1; i < `PLIC_NDEV; i++) begin
            if (src[i]) begin
                pending_nxt[i] = 1'b1; // Level or pulse, latched alike
            end
        end
        // Claim beats a source seen in the same cycle
        if (claim_stb) begin
            pending_nxt[claim.id] = 1'b0;
        end
        pending_nxt[0] = 1'b0; // Source 0 is no interrupt
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= pending_nxt;
        end
    end

    // Nothing may ever become pending as source 0
    assert property (@(posedge clk) disable iff (rst) !pending[0]);

endmodule

// ==== design/plic_target.sv ====
`timescale 1ns/1ps
`include "plic_settings.svh"

module plic_target (
    input  plic_pkg::plic_src_t  pending,
    input  plic_pkg::plic_src_t  en,
    input  plic_pkg::plic_word_t prio [`PLIC_NDEV],
    input  plic_pkg::plic_word_t thresh,
    output plic_pkg::plic_id_t   best
);
    import plic_pkg::*;

    plic_src_t  eligible;
    plic_word_t best_prio;

    // Pending, enabled and strictly above this context's threshold
    always_comb begin
        eligible = pending & en;
        for (int i = 0; i < `PLIC_NDEV; i++) begin
            if (prio[i] <= thresh) begin
                eligible[i] = 1'b0;
            end
        end
        eligible[0] = 1'b0;
    end

    // Strict compare keeps the lowest id on equal priority
    always_comb begin
        best      = '0;
        best_prio = '0;
        for (int i = 1; i < `PLIC_NDEV; i++) begin
            if (eligible[i] && prio[i] > best_prio) begin
                best      = plic_id_t'(i);
                best_prio = prio[i];
            end
        end
    end

endmodule

// ==== design/plic_regs.sv ====
`timescale 1ns/1ps
`include "plic_settings.svh"

module plic_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_stb,
    input  plic_pkg::plic_wr_t    wr,
    input  logic                  rd_stb,
    input  plic_pkg::plic_addr_t  rd_addr,
    input  plic_pkg::plic_src_t   pending,
    input  plic_pkg::plic_id_t    best [`PLIC_NCTX],
    output plic_pkg::plic_word_t  rd_data,
    output logic                  claim_stb,
    output plic_pkg::plic_claim_t claim,
    output plic_pkg::plic_word_t  prio [`PLIC_NDEV],
    output plic_pkg::plic_src_t   en [`PLIC_NCTX],
    output plic_pkg::plic_word_t  thresh [`PLIC_NCTX]
);
    import plic_pkg::*;

    logic claim_hit;
    logic claim_ctx;

    function automatic plic_addr_t prio_addr(input int i);
        return `PLIC_PRIO_BASE + plic_addr_t'(i * `PLIC_WORD_BYTES);
    endfunction

    function automatic plic_addr_t en_addr(input int c);
        return `PLIC_EN_BASE + plic_addr_t'(c) * `PLIC_EN_STRIDE;
    endfunction

    function automatic plic_addr_t thr_addr(input int c);
        return `PLIC_CTX_BASE + plic_addr_t'(c) * `PLIC_CTX_STRIDE;
    endfunction

    // Register writes; pending and completion addresses fall through
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PLIC_NDEV; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < `PLIC_NCTX; c++) begin
                en[c]     <= '0;
                thresh[c] <= '0;
            end
        end else if (wr_stb) begin
            for (int i = 1; i < `PLIC_NDEV; i++) begin
                if (wr.addr == prio_addr(i)) begin
                    prio[i] <= wr.data; // prio[0] stays zero
                end
            end
            for (int c = 0; c < `PLIC_NCTX; c++) begin
                if (wr.addr == en_addr(c)) begin
                    en[c] <= plic_src_t'(wr.data);
                end
                if (wr.addr == thr_addr(c)) begin
                    thresh[c] <= wr.data;
                end
            end
        end
    end

    // Read decode with zero for unmapped addresses
    always_comb begin
        rd_data   = '0;
        claim_hit = 1'b0;
        claim_ctx = 1'b0;
        for (int i = 0; i < `PLIC_NDEV; i++) begin
            if (rd_addr == prio_addr(i)) begin
                rd_data = prio[i];
            end
        end
        if (rd_addr == `PLIC_PEND_BASE) begin
            rd_data = plic_word_t'(pending);
        end
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            if (rd_addr == en_addr(c)) begin
                rd_data = plic_word_t'(en[c]);
            end
            if (rd_addr == thr_addr(c)) begin
                rd_data = thresh[c];
            end
            if (rd_addr == thr_addr(c) + `PLIC_CLAIM_OFS) begin
                rd_data   = plic_word_t'(best[c]); // Claim returns current winner
                claim_hit = 1'b1;
                claim_ctx = 1'(c);
            end
        end
    end

    assign claim_stb = rd_stb && claim_hit;
    assign claim.id  = best[claim_ctx];
    assign claim.ctx = claim_ctx;

    // A claim only ever clears a source that is pending
    assert property (@(posedge clk) disable iff (rst)
        claim_stb |-> (claim.id == '0 || pending[claim.id]));

endmodule

// ==== design/plic.sv ====
`timescale 1ns/1ps
`include "plic_settings.svh"

module plic (
    input  logic                 clk,
    input  logic                 rst,
    input  plic_pkg::plic_src_t  src,      // Device interrupt lines
    output logic [63:0]          int_pend, // To core mip
    input  plic_pkg::plic_addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  plic_pkg::plic_word_t wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output logic                 bvalid,
    input  logic                 bready,
    input  plic_pkg::plic_addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic                 rvalid,
    output plic_pkg::plic_word_t rdata,
    input  logic                 rready
);
    import plic_pkg::*;

    logic        wr_stb;
    plic_wr_t    wr;
    logic        rd_stb;
    plic_addr_t  rd_addr;
    plic_word_t  rd_data;
    logic        claim_stb;
    plic_claim_t claim;
    plic_src_t   pending;
    plic_word_t  prio [`PLIC_NDEV];
    plic_src_t   en [`PLIC_NCTX];
    plic_word_t  thresh [`PLIC_NCTX];
    plic_id_t    best [`PLIC_NCTX];

    plic_axi_port u_port (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rready  (rready),
        .wr_stb  (wr_stb),
        .wr      (wr),
        .rd_stb  (rd_stb),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    plic_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wr_stb    (wr_stb),
        .wr        (wr),
        .rd_stb    (rd_stb),
        .rd_addr   (rd_addr),
        .pending   (pending),
        .best      (best),
        .rd_data   (rd_data),
        .claim_stb (claim_stb),
        .claim     (claim),
        .prio      (prio),
        .en        (en),
        .thresh    (thresh)
    );

    plic_gateway u_gateway (
        .clk       (clk),
        .rst       (rst),
        .src       (src),
        .claim_stb (claim_stb),
        .claim     (claim),
        .pending   (pending)
    );

    for (genvar c = 0; c < `PLIC_NCTX; c++) begin : g_ctx
        plic_target u_target (
            .pending (pending),
            .en      (en[c]),
            .prio    (prio),
            .thresh  (thresh[c]),
            .best    (best[c])
        );
    end

    // Context 0 is MEIP (bit 11), context 1 is SEIP (bit 9)
    always_ff @(posedge clk) begin
        if (rst) begin
            int_pend <= '0;
        end else begin
            int_pend <= '0;
            for (int c = 0; c < `PLIC_NCTX; c++) begin
                int_pend[(c == 0) ? 11 : 9] <= |best[c];
            end
        end
    end

endmodule

// ==== dv/plic_tb.sv ====
`timescale 1ns/1ps
`include "plic_settings.svh"

module plic_tb;
    import plic_pkg::*;

    localparam logic [1:0] OP_WR    = 2'd0; // Bus write of data
    localparam logic [1:0] OP_RD    = 2'd1; // Bus read compared with exp
    localparam logic [1:0] OP_PULSE = 2'd2; // One-cycle src pulse of data
    localparam logic [1:0] OP_INT   = 2'd3; // int_pend once settled
    localparam int ROUNDS    = 3;
    localparam int ROUND_OPS = 2 * `PLIC_NDEV + 2; // Bus and poll steps per round

    localparam plic_addr_t A_PEND = `PLIC_PEND_BASE;
    localparam plic_addr_t A_EN0  = `PLIC_EN_BASE;
    localparam plic_addr_t A_EN1  = `PLIC_EN_BASE + `PLIC_EN_STRIDE;
    localparam plic_addr_t A_THR0 = `PLIC_CTX_BASE;
    localparam plic_addr_t A_THR1 = `PLIC_CTX_BASE + `PLIC_CTX_STRIDE;
    localparam plic_addr_t A_CLM0 = A_THR0 + `PLIC_CLAIM_OFS;
    localparam plic_addr_t A_CLM1 = A_THR1 + `PLIC_CLAIM_OFS;

    typedef struct packed {
        logic [1:0]  op;
        plic_addr_t  addr;
        plic_word_t  data;
        logic [63:0] exp;
    } step_t;

    logic        clk = 1'b0;
    logic        rst;
    plic_src_t   src;
    logic [63:0] int_pend;
    plic_addr_t  awaddr, araddr;
    plic_word_t  wdata, rdata;
    logic        awvalid, wvalid, bready, arvalid, rready; // Driven by the testbench
    logic        awready, wready, bvalid, arready, rvalid;

    int         errors = 0;
    integer     seed = 71240;
    string      waiting_on = "a test step";
    step_t      tbl [$];
    plic_word_t rnd_prio [`PLIC_NDEV];

    always #50 clk = ~clk;

    plic u_plic (.*);

    function automatic plic_addr_t prio_at(input int n);
        return `PLIC_PRIO_BASE + plic_addr_t'(4 * n);
    endfunction

    task automatic check_word(input string name, input plic_word_t got, input plic_word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_int(input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED int_pend: got %h, expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic axi_write(input plic_addr_t a, input plic_word_t d, input int stall);
        @(posedge clk);
        #5;
        awaddr  = a;
        wdata   = d;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waiting_on = "write address and data ready";
        while (!(awready && wready)) begin
            @(posedge clk);
            #5;
        end
        @(posedge clk); // Both halves accepted here
        #5;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waiting_on = "write response";
        while (!bvalid) begin
            @(posedge clk);
            #5;
        end
        awvalid = (stall > 0); // Second request must wait for the response
        wvalid  = (stall > 0);
        wdata   = ~d;
        repeat (stall) begin
            @(posedge clk);
            #5;
            if (!bvalid || awready || wready) begin
                $display("Write response or write readies changed while bready was low");
                errors++;
            end
        end
        bready = 1'b1;
        @(posedge clk);
        #5;
        bready  = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axi_read(input plic_addr_t a, input int stall, output plic_word_t d);
        @(posedge clk);
        #5;
        araddr  = a;
        arvalid = 1'b1;
        waiting_on = "read address ready";
        while (!arready) begin
            @(posedge clk);
            #5;
        end
        @(posedge clk);
        #5;
        arvalid = 1'b0;
        waiting_on = "read data";
        while (!rvalid) begin
            @(posedge clk);
            #5;
        end
        d = rdata;
        arvalid = (stall > 0); // Held request stays blocked
        repeat (stall) begin
            @(posedge clk);
            #5;
            if (!rvalid || arready) begin
                $display("Read data or read address ready changed while rready was low");
                errors++;
            end
            check_word("rdata", rdata, d);
        end
        rready = 1'b1;
        @(posedge clk);
        #5;
        rready  = 1'b0;
        arvalid = 1'b0;
    endtask

    task automatic pulse_src(input plic_src_t m);
        @(posedge clk);
        #5;
        src = m;
        @(posedge clk);
        #5;
        src = '0;
    endtask

    // Three unchanged cycles count as settled
    task automatic poll_int(input logic [63:0] exp);
        logic [63:0] last;
        int          same;
        same = 0;
        waiting_on = "int_pend to settle";
        while (same < 3) begin
            last = int_pend;
            @(posedge clk);
            #5;
            same = (int_pend == last) ? same + 1 : 0;
        end
        check_int(int_pend, exp);
    endtask

    // Threshold 0 in the random rounds; scanning down lets the lower id win ties
    function automatic plic_id_t expect_claim(input plic_src_t pend);
        plic_id_t   id;
        plic_word_t top;
        id  = '0;
        top = '0;
        for (int i = `PLIC_NDEV - 1; i > 0; i--) begin
            if (pend[i] && rnd_prio[i] != 0 && rnd_prio[i] >= top) begin
                id  = plic_id_t'(i);
                top = rnd_prio[i];
            end
        end
        return id;
    endfunction

    initial begin
        plic_word_t d;
        plic_src_t  pend;
        plic_id_t   id;
        step_t      s;
        rst = 1'b1;
        {src, awaddr, araddr, wdata, awvalid, wvalid, bready, arvalid, rready} = '0;

        // Register read back, pending word and unmapped space
        tbl.push_back({OP_WR, prio_at(1), 32'h5, 64'h0});
        tbl.push_back({OP_RD, prio_at(1), 32'h0, 64'h5});
        tbl.push_back({OP_WR, A_EN0, 32'h1ff, 64'h0});
        tbl.push_back({OP_RD, A_EN0, 32'h0, 64'hff}); // One bit per source only
        tbl.push_back({OP_WR, A_THR1, 32'hdeadbeef, 64'h0});
        tbl.push_back({OP_RD, A_THR1, 32'h0, 64'hdeadbeef});
        tbl.push_back({OP_WR, A_PEND, 32'hff, 64'h0});
        tbl.push_back({OP_RD, A_PEND, 32'h0, 64'h0});
        tbl.push_back({OP_RD, 28'hc000100, 32'h0, 64'h0}); // Past the priority block
        // Source 3 alone in context 0
        tbl.push_back({OP_WR, prio_at(3), 32'h2, 64'h0});
        tbl.push_back({OP_WR, A_EN0, 32'h08, 64'h0});
        tbl.push_back({OP_PULSE, 28'h0, 32'h08, 64'h0});
        tbl.push_back({OP_RD, A_PEND, 32'h0, 64'h08});
        tbl.push_back({OP_INT, 28'h0, 32'h0, 64'h800});
        tbl.push_back({OP_RD, A_CLM0, 32'h0, 64'h3});
        tbl.push_back({OP_INT, 28'h0, 32'h0, 64'h0});
        // Threshold equal to priority masks it
        tbl.push_back({OP_WR, A_THR0, 32'h2, 64'h0});
        tbl.push_back({OP_PULSE, 28'h0, 32'h08, 64'h0});
        tbl.push_back({OP_INT, 28'h0, 32'h0, 64'h0});
        tbl.push_back({OP_RD, A_CLM0, 32'h0, 64'h0});
        tbl.push_back({OP_WR, prio_at(3), 32'h3, 64'h0});
        tbl.push_back({OP_INT, 28'h0, 32'h0, 64'h800});
        tbl.push_back({OP_RD, A_CLM0, 32'h0, 64'h3});
        tbl.push_back({OP_WR, A_THR0, 32'h0, 64'h0});
        // Claim order with priorities 1:5 2:6 3:3 5:6
        tbl.push_back({OP_WR, prio_at(2), 32'h6, 64'h0});
        tbl.push_back({OP_WR, prio_at(5), 32'h6, 64'h0});
        tbl.push_back({OP_WR, A_EN0, 32'h2e, 64'h0});
        tbl.push_back({OP_PULSE, 28'h0, 32'h2e, 64'h0});
        tbl.push_back({OP_RD, A_CLM0, 32'h0, 64'h2});
        tbl.push_back({OP_RD, A_PEND, 32'h0, 64'h2a});
        tbl.push_back({OP_RD, A_CLM0, 32'h0, 64'h5});
        tbl.push_back({OP_RD, A_CLM0, 32'h0, 64'h1});
        tbl.push_back({OP_RD, A_CLM0, 32'h0, 64'h3});
        tbl.push_back({OP_INT, 28'h0, 32'h0, 64'h0});
        // Source 4 only in context 1, above its threshold
        tbl.push_back({OP_WR, A_EN0, 32'h0, 64'h0});
        tbl.push_back({OP_WR, A_EN1, 32'h10, 64'h0});
        tbl.push_back({OP_WR, prio_at(4), 32'hffffffff, 64'h0});
        tbl.push_back({OP_PULSE, 28'h0, 32'h10, 64'h0});
        tbl.push_back({OP_INT, 28'h0, 32'h0, 64'h200});
        tbl.push_back({OP_RD, A_CLM0, 32'h0, 64'h0});
        tbl.push_back({OP_RD, A_CLM1, 32'h0, 64'h4});
        tbl.push_back({OP_INT, 28'h0, 32'h0, 64'h0});

        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        for (int k = 0; k < tbl.size(); k++) begin
            s = tbl[k];
            case (s.op)
                OP_WR: axi_write(s.addr, s.data, 0);
                OP_RD: begin
                    axi_read(s.addr, 0, d);
                    check_word("rdata", d, s.exp[31:0]);
                end
                OP_PULSE: pulse_src(plic_src_t'(s.data));
                default: poll_int(s.exp);
            endcase
        end

        // Random priorities 1 to 4 on every source in context 0
        pend = '1;
        pend[0] = 1'b0;
        axi_write(A_EN0, plic_word_t'(pend), 0);
        for (int r = 0; r < ROUNDS; r++) begin
            for (int i = 1; i < `PLIC_NDEV; i++) begin
                rnd_prio[i] = plic_word_t'(($random(seed) & 3) + 1);
                axi_write(prio_at(i), rnd_prio[i], 0);
            end
            pend = '1;
            pend[0] = 1'b0;
            pulse_src(pend);
            repeat (`PLIC_NDEV) begin
                id = expect_claim(pend);
                axi_read(A_CLM0, 0, d);
                check_word("claim", d, plic_word_t'(id));
                pend[id] = 1'b0;
            end
            axi_read(A_PEND, 0, d);
            check_word("pending", d, plic_word_t'(pend));
            poll_int(64'h0);
        end

        // Responses held by bready and rready
        axi_write(prio_at(6), 32'h55, 5);
        axi_read(prio_at(6), 5, d);
        check_word("rdata", d, 32'h55);
        axi_read(prio_at(6), 0, d);
        check_word("rdata", d, 32'h55);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // 20 clock periods for each table step and each random bus step
    initial begin
        #1;
        #((tbl.size() + ROUNDS * ROUND_OPS) * 20 * 100);
        $display("Timeout while waiting for %s", waiting_on);
        $display("Checks stopped with %0d errors", errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
design/plic_pkg.sv
design/plic_axi_port.sv
design/plic_gateway.sv
design/plic_target.sv
design/plic_regs.sv
design/plic.sv
dv/plic_tb.sv
